//--- Bender.yml
package:
  name: fetch_top

sources:
  # RTL in compile order
  - files:
      - logic/fetch_pkg.sv
      - logic/icache_store.sv
      - logic/icache_ctrl.sv
      - logic/fetch_unit.sv
      - logic/boot_rom.sv
      - logic/fetch_top.sv

  # testbench
  - target: simulation
    files:
      - sim/tb_fetch_top.sv

//--- logic/boot_rom.hex
// one 32-bit instruction word per line, word address 0 to 31 in order
00000093
00100093
00200093
00300093
00400093
00500093
00600093
00700093
00800093
00900093
00A00093
00B00093
00C00093
00D00093
00E00093
00F00093
01000093
01100093
01200093
01300093
01400093
01500093
01600093
01700093
01800093
01900093
01A00093
01B00093
01C00093
01D00093
01E00093
01F00093

//--- logic/boot_rom.sv
// read-only program memory behind the cache
// accepts one block address, waits a fixed number of cycles
// then streams the block word by word and flags the last beat
`timescale 1ns/100ps
`default_nettype none

module boot_rom (
	input  wire         clk,
	input  wire         rst,
	input  wire  [31:0] mem_addr,
	input  wire         mem_valid,
	output logic        mem_ready,
	output logic [31:0] mem_data,
	output logic        mem_data_valid,
	output logic        mem_last,
	input  wire         mem_data_ready
);
	import fetch_pkg::*;

	logic [31:0]                    rom [0:(1 << ROM_WORDS_LOG2)-1];
	logic                           busy;
	logic [$clog2(ROM_WAIT+1)-1:0]  wait_cnt;
	logic [ROM_WORDS_LOG2-1:0]      word_ptr;
	logic [BLOCK_WORDS_LOG2-1:0]    beat_cnt;

	initial begin
		$readmemh(ROM_IMAGE, rom);
	end

	assign mem_ready = !busy;
	assign mem_data  = rom[word_ptr];
	assign mem_last  = mem_data_valid && (beat_cnt == BLOCK_WORDS_LOG2'(BLOCK_WORDS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			busy           <= 1'b0;
			mem_data_valid <= 1'b0;
			wait_cnt       <= '0;
			beat_cnt       <= '0;
		end else if (!busy) begin
			if (mem_valid) begin
				busy     <= 1'b1;
				wait_cnt <= '0;
				beat_cnt <= '0;
			end
		end else if (!mem_data_valid) begin
			// wait states before the first beat
			if (wait_cnt == ROM_WAIT - 1) begin
				mem_data_valid <= 1'b1;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end else if (mem_data_ready) begin
			// beat held until taken
			beat_cnt <= beat_cnt + 1'b1;
			if (mem_last) begin
				busy           <= 1'b0;
				mem_data_valid <= 1'b0;
			end
		end
	end

	// block base, wraps at the ROM size
	always_ff @(posedge clk) begin
		if (!busy && mem_valid) begin
			word_ptr <= {mem_addr[2 + BLOCK_WORDS_LOG2 +: ROM_WORDS_LOG2 - BLOCK_WORDS_LOG2],
				{BLOCK_WORDS_LOG2{1'b0}}};
		end else if (mem_data_valid && mem_data_ready) begin
			word_ptr <= word_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/fetch_pkg.sv
// shared constants of the instruction fetch subsystem
// address split of the direct-mapped cache, block and ROM sizes
// ROM wait states, reset pc and program image path
`default_nettype none

package fetch_pkg;

	// two words per block, one refill burst per block
	localparam int BLOCK_WORDS_LOG2 = 1;
	localparam int BLOCK_WORDS = 1 << BLOCK_WORDS_LOG2;

	// eight lines, so 64 bytes cached in total
	localparam int LINE_NUM_LOG2 = 3;

	// byte offset inside a block
	// word select sits at bit 2 and up
	localparam int OFFSET_BITS = BLOCK_WORDS_LOG2 + 2;

	// everything above index and offset
	localparam int TAG_BITS = 32 - LINE_NUM_LOG2 - OFFSET_BITS;

	// 32 words of program, addresses wrap at 128 bytes
	localparam int ROM_WORDS_LOG2 = 5;

	// cycles from burst address acceptance to first beat
	localparam int ROM_WAIT = 3;

	// first fetch address after reset
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	// hex image, one 32-bit word per line
	localparam ROM_IMAGE = "logic/boot_rom.hex";

endpackage

`default_nettype wire

//--- logic/fetch_top.sv
// top of the instruction fetch subsystem
// fetch unit, cache control and storage, boot ROM
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
	input  wire         clk,
	input  wire         rst,
	input  wire         redirect_valid,
	input  wire  [31:0] redirect_pc,
	input  wire         flush,
	output logic [31:0] inst,
	output logic [31:0] inst_pc,
	output logic        inst_valid,
	input  wire         inst_ready
);
	import fetch_pkg::*;

	// fetch to cache
	logic [31:0] req_addr;
	logic        req_valid;
	logic        req_ready;
	logic [31:0] rsp_data;
	logic        rsp_valid;
	logic        rsp_ready;

	// cache to ROM
	logic [31:0] mem_addr;
	logic        mem_valid;
	logic        mem_ready;
	logic [31:0] mem_data;
	logic        mem_data_valid;
	logic        mem_last;
	logic        mem_data_ready;

	// controller to store
	logic [31:0]                 rd_addr;
	logic                        rd_hit;
	logic [31:0]                 rd_word;
	logic                        wr_en;
	logic [31:0]                 wr_addr;
	logic [BLOCK_WORDS_LOG2-1:0] wr_word_sel;
	logic [31:0]                 wr_data;
	logic                        wr_line_valid;
	logic                        flush_all;

	fetch_unit u_fetch (
		.clk(clk), .rst(rst),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.req_addr(req_addr), .req_valid(req_valid), .req_ready(req_ready),
		.rsp_data(rsp_data), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
		.inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid), .inst_ready(inst_ready)
	);

	icache_ctrl u_ctrl (
		.clk(clk), .rst(rst), .flush(flush),
		.req_addr(req_addr), .req_valid(req_valid), .req_ready(req_ready),
		.rsp_data(rsp_data), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
		.mem_addr(mem_addr), .mem_valid(mem_valid), .mem_ready(mem_ready),
		.mem_data(mem_data), .mem_data_valid(mem_data_valid), .mem_last(mem_last),
		.mem_data_ready(mem_data_ready),
		.rd_addr(rd_addr), .rd_hit(rd_hit), .rd_word(rd_word),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_word_sel(wr_word_sel), .wr_data(wr_data),
		.wr_line_valid(wr_line_valid), .flush_all(flush_all)
	);

	icache_store u_store (
		.clk(clk), .rst(rst),
		.rd_addr(rd_addr), .rd_hit(rd_hit), .rd_word(rd_word),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_word_sel(wr_word_sel), .wr_data(wr_data),
		.wr_line_valid(wr_line_valid), .flush_all(flush_all)
	);

	boot_rom u_rom (
		.clk(clk), .rst(rst),
		.mem_addr(mem_addr), .mem_valid(mem_valid), .mem_ready(mem_ready),
		.mem_data(mem_data), .mem_data_valid(mem_data_valid), .mem_last(mem_last),
		.mem_data_ready(mem_data_ready)
	);

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
// instruction fetch unit
// pc register, one outstanding request to the cache
// redirect with discard of the stale response
// output instruction register on a valid/ready stream
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
	input  wire         clk,
	input  wire         rst,
	input  wire         redirect_valid,
	input  wire  [31:0] redirect_pc,
	output logic [31:0] req_addr,
	output logic        req_valid,
	input  wire         req_ready,
	input  wire  [31:0] rsp_data,
	input  wire         rsp_valid,
	output logic        rsp_ready,
	output logic [31:0] inst,
	output logic [31:0] inst_pc,
	output logic        inst_valid,
	input  wire         inst_ready
);
	import fetch_pkg::*;

	logic        run;
	logic        pending;
	logic        discard;
	logic [31:0] pc;
	logic [31:0] flight_pc;
	logic        req_fire;
	logic        rsp_fire;
	logic        deliver;

	// first request one cycle after reset
	// then only with nothing in flight and nothing held
	assign req_addr  = pc;
	assign req_valid = run && !pending && !inst_valid;
	assign rsp_ready = !inst_valid;

	assign req_fire = req_valid && req_ready;
	assign rsp_fire = rsp_valid && rsp_ready;
	assign deliver  = inst_valid && inst_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			run        <= 1'b0;
			pending    <= 1'b0;
			discard    <= 1'b0;
			inst_valid <= 1'b0;
			pc         <= RESET_PC;
		end else begin
			run <= 1'b1;
			if (req_fire) begin
				pending <= 1'b1;
			end else if (rsp_fire) begin
				pending <= 1'b0;
			end
			if (redirect_valid) begin
				// held word is wrong path, drop it
				pc         <= redirect_pc;
				inst_valid <= 1'b0;
				// old request still owes a response
				discard    <= req_fire || (pending && !rsp_fire);
			end else begin
				if (rsp_fire) begin
					discard    <= 1'b0;
					inst_valid <= !discard;
				end
				if (deliver) begin
					inst_valid <= 1'b0;
					pc         <= pc + 32'd4;
				end
			end
		end
	end

	// address in flight, captured instruction
	always_ff @(posedge clk) begin
		if (req_fire) begin
			flight_pc <= pc;
		end
		if (rsp_fire) begin
			inst    <= rsp_data;
			inst_pc <= flight_pc;
		end
	end

endmodule

`default_nettype wire

//--- logic/icache_ctrl.sv
// control of the direct-mapped instruction cache
// idle, respond, address wait and refill states
// hit returns the stored word, miss refills a block by burst
// flush clears all lines, deferred while a request is busy
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl (
	input  wire                                   clk,
	input  wire                                   rst,
	input  wire                                   flush,
	// fetch side
	input  wire  [31:0]                           req_addr,
	input  wire                                   req_valid,
	output logic                                  req_ready,
	output logic [31:0]                           rsp_data,
	output logic                                  rsp_valid,
	input  wire                                   rsp_ready,
	// ROM side
	output logic [31:0]                           mem_addr,
	output logic                                  mem_valid,
	input  wire                                   mem_ready,
	input  wire  [31:0]                           mem_data,
	input  wire                                   mem_data_valid,
	input  wire                                   mem_last,
	output logic                                  mem_data_ready,
	// store side
	output logic [31:0]                           rd_addr,
	input  wire                                   rd_hit,
	input  wire  [31:0]                           rd_word,
	output logic                                  wr_en,
	output logic [31:0]                           wr_addr,
	output logic [fetch_pkg::BLOCK_WORDS_LOG2-1:0] wr_word_sel,
	output logic [31:0]                           wr_data,
	output logic                                  wr_line_valid,
	output logic                                  flush_all
);
	import fetch_pkg::*;

	// state encoding
	localparam logic [1:0] S_IDLE    = 2'd0;
	localparam logic [1:0] S_RESPOND = 2'd1;
	localparam logic [1:0] S_ADDR    = 2'd2;
	localparam logic [1:0] S_REFILL  = 2'd3;

	logic [1:0]                  state;
	logic [31:0]                 miss_addr;
	logic [BLOCK_WORDS_LOG2-1:0] beat_cnt;
	logic [BLOCK_WORDS_LOG2-1:0] want_sel;
	logic                        flush_pend;
	logic                        req_fire;
	logic                        beat_fire;

	// no new request while a flush waits
	assign req_ready = (state == S_IDLE) && !flush && !flush_pend;
	assign req_fire  = req_valid && req_ready;
	assign beat_fire = (state == S_REFILL) && mem_data_valid;

	// store looks up the incoming address
	assign rd_addr = req_addr;

	// flush only applied in idle
	// one cycle, then requests accepted again
	assign flush_all = (state == S_IDLE) && (flush || flush_pend);

	// word the fetch unit asked for
	assign want_sel = miss_addr[2 +: BLOCK_WORDS_LOG2];

	// burst always starts at the block base
	assign mem_addr       = {miss_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	assign mem_valid      = (state == S_ADDR);
	assign mem_data_ready = (state == S_REFILL);

	// every refill beat lands in the store
	assign wr_en         = beat_fire;
	assign wr_addr       = miss_addr;
	assign wr_word_sel   = beat_cnt;
	assign wr_data       = mem_data;
	// line becomes valid with its tag on the last beat
	assign wr_line_valid = beat_fire && mem_last;

	assign rsp_valid = (state == S_RESPOND);

	// state machine and beat counter
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= S_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (req_fire) begin
						beat_cnt <= '0;
						if (rd_hit) begin
							state <= S_RESPOND;
						end else begin
							state <= S_ADDR;
						end
					end
				end
				S_RESPOND: begin
					if (rsp_ready) begin
						state <= S_IDLE;
					end
				end
				S_ADDR: begin
					// ROM takes the block address
					if (mem_ready) begin
						state <= S_REFILL;
					end
				end
				S_REFILL: begin
					if (mem_data_valid) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (mem_last) begin
							state <= S_RESPOND;
						end
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// flush seen while busy waits for idle
	always_ff @(posedge clk) begin
		if (rst) begin
			flush_pend <= 1'b0;
		end else if (state == S_IDLE) begin
			flush_pend <= 1'b0;
		end else if (flush) begin
			flush_pend <= 1'b1;
		end
	end

	// request address and returned word
	always_ff @(posedge clk) begin
		if (req_fire) begin
			miss_addr <= req_addr;
			rsp_data  <= rd_word;
		end
		// pick the requested word out of the burst
		if (beat_fire && (beat_cnt == want_sel)) begin
			rsp_data <= mem_data;
		end
	end

endmodule

`default_nettype wire

//--- logic/icache_store.sv
// storage of the direct-mapped instruction cache
// per-line valid bit and tag, block data words
// combinational read with hit compare, refill write port and flush
`timescale 1ns/100ps
`default_nettype none

module icache_store (
	input  wire                                   clk,
	input  wire                                   rst,
	input  wire  [31:0]                           rd_addr,
	output logic                                  rd_hit,
	output logic [31:0]                           rd_word,
	input  wire                                   wr_en,
	input  wire  [31:0]                           wr_addr,
	input  wire  [fetch_pkg::BLOCK_WORDS_LOG2-1:0] wr_word_sel,
	input  wire  [31:0]                           wr_data,
	input  wire                                   wr_line_valid,
	input  wire                                   flush_all
);
	import fetch_pkg::*;

	// fields of the read and write addresses
	logic [TAG_BITS-1:0]         rd_tag;
	logic [LINE_NUM_LOG2-1:0]    rd_index;
	logic [BLOCK_WORDS_LOG2-1:0] rd_sel;
	logic [TAG_BITS-1:0]         wr_tag;
	logic [LINE_NUM_LOG2-1:0]    wr_index;

	// one valid bit and one tag per line
	logic [(1 << LINE_NUM_LOG2)-1:0] line_valid;
	logic [TAG_BITS-1:0]             tag_mem [0:(1 << LINE_NUM_LOG2)-1];
	// words kept line after line, word select in the low address bits
	logic [31:0] data_mem [0:(1 << (LINE_NUM_LOG2 + BLOCK_WORDS_LOG2))-1];

	// tag | index | word | byte
	assign rd_tag   = rd_addr[OFFSET_BITS + LINE_NUM_LOG2 +: TAG_BITS];
	assign rd_index = rd_addr[OFFSET_BITS +: LINE_NUM_LOG2];
	assign rd_sel   = rd_addr[2 +: BLOCK_WORDS_LOG2];
	assign wr_tag   = wr_addr[OFFSET_BITS + LINE_NUM_LOG2 +: TAG_BITS];
	assign wr_index = wr_addr[OFFSET_BITS +: LINE_NUM_LOG2];

	// hit needs a valid line and a matching tag
	assign rd_hit  = line_valid[rd_index] && (tag_mem[rd_index] == rd_tag);
	assign rd_word = data_mem[{rd_index, rd_sel}];

	// valid bits, flush wins over a line fill
	always_ff @(posedge clk) begin
		if (rst) begin
			line_valid <= '0;
		end else if (flush_all) begin
			line_valid <= '0;
		end else if (wr_line_valid) begin
			line_valid[wr_index] <= 1'b1;
		end
	end

	// tag written with the last refill beat
	always_ff @(posedge clk) begin
		if (wr_line_valid) begin
			tag_mem[wr_index] <= wr_tag;
		end
		if (wr_en) begin
			data_mem[{wr_index, wr_word_sel}] <= wr_data;
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_fetch_top.sv
// testbench of the instruction fetch subsystem
// clock, reset, stimulus tasks and a reference model of the program
// compare process on the output stream, per-test and closing report
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_top;
	import fetch_pkg::*;

	// about three times the summed test lengths
	localparam int MAX_CYCLES = 4000;
	// cycles between words of a hit stretch
	localparam int HIT_GAP = 3;

	logic        clk;
	logic        rst;
	logic        redirect_valid;
	logic [31:0] redirect_pc;
	logic        flush;
	logic        inst_ready;
	wire  [31:0] inst;
	wire  [31:0] inst_pc;
	wire         inst_valid;

	// program image as the testbench sees it
	logic [31:0] ref_rom [0:(1 << ROM_WORDS_LOG2)-1];

	// expected-pc model and bookkeeping of the compare process
	logic [31:0] exp_pc = RESET_PC;
	logic [31:0] last_pc = '0;
	logic [31:0] held_inst = '0;
	logic [31:0] held_pc = '0;
	logic        hold_chk = 1'b0;
	logic        timing_on = 1'b0;
	int          cycles = 0;
	int          last_cycle = 0;
	int          n_deliv = 0;
	int          err_cnt = 0;
	int          check_cnt = 0;
	int          test_cnt = 0;

	fetch_top u_dut (
		.clk(clk), .rst(rst),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.flush(flush),
		.inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid), .inst_ready(inst_ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// word at pc / 4 modulo the ROM size
	function automatic logic [31:0] expected_inst(input logic [31:0] pc);
		return ref_rom[pc[2 +: ROM_WORDS_LOG2]];
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("FAIL time %0t signal %s expected %h actual %h", $time, name, exp_val, act_val);
		err_cnt++;
	endtask

	// outputs sampled before the edge updates them
	always @(posedge clk) begin
		cycles++;
		if (rst) begin
			exp_pc = RESET_PC;
			hold_chk = 1'b0;
		end else begin
			// held output must not move under back-pressure
			if (hold_chk) begin
				check_cnt++;
				if (!inst_valid) begin
					report_mismatch("inst_valid", 32'd1, {31'd0, inst_valid});
				end
				if (inst !== held_inst) begin
					report_mismatch("inst", held_inst, inst);
				end
				if (inst_pc !== held_pc) begin
					report_mismatch("inst_pc", held_pc, inst_pc);
				end
			end
			hold_chk = inst_valid && !inst_ready && !redirect_valid;
			held_inst = inst;
			held_pc = inst_pc;
			if (redirect_valid) begin
				// model restarts at the redirect target
				exp_pc = redirect_pc;
			end else if (inst_valid && inst_ready) begin
				check_cnt++;
				if (inst_pc !== exp_pc) begin
					report_mismatch("inst_pc", exp_pc, inst_pc);
				end
				if (inst !== expected_inst(exp_pc)) begin
					report_mismatch("inst", expected_inst(exp_pc), inst);
				end
				// hit stretch delivers one word every 3 cycles
				if (timing_on && (inst_pc == last_pc + 32'd4)
					&& (cycles - last_cycle != HIT_GAP)) begin
					report_mismatch("delivery interval", HIT_GAP, cycles - last_cycle);
				end
				last_pc = inst_pc;
				last_cycle = cycles;
				n_deliv++;
				exp_pc = exp_pc + 32'd4;
			end
		end
	end

	initial begin
		wait (cycles >= MAX_CYCLES);
		$display("timeout after %0d cycles, the instruction stream is stuck", MAX_CYCLES);
		$display("Test failures found");
		$finish;
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// one-cycle redirect
	task automatic send_redirect(input logic [31:0] target);
		redirect_valid = 1'b1;
		redirect_pc = target;
		next_cycle();
		redirect_valid = 1'b0;
	endtask

	task automatic pulse_flush();
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
	endtask

	task automatic wait_deliveries(input int n);
		int target;
		target = n_deliv + n;
		while (n_deliv < target) begin
			next_cycle();
		end
	endtask

	task automatic wait_for_pc(input logic [31:0] target);
		int   seen;
		logic found;
		found = 1'b0;
		while (!found) begin
			seen = n_deliv;
			next_cycle();
			found = (n_deliv != seen) && (last_pc == target);
		end
	endtask

	// returns two cycles into the ROM wait states of the target block
	task automatic wait_refill(input logic [31:0] target);
		while (!u_dut.mem_valid
			|| (u_dut.mem_addr[31:OFFSET_BITS] != target[31:OFFSET_BITS])) begin
			next_cycle();
		end
		next_cycle();
		next_cycle();
	endtask

	// a flushed line is refilled, slower than a hit plus the flush cycle
	task automatic check_refill_gap(input int prev_cycle, input logic [31:0] pc);
		check_cnt++;
		if (last_cycle - prev_cycle <= HIT_GAP + 1) begin
			$display("FAIL time %0t pc %h still cached after flush, gap %0d cycles",
				$time, pc, last_cycle - prev_cycle);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			$display("%s: done, no errors", name);
		end else begin
			$display("%s: done, %0d errors", name, err_cnt - errs_before);
		end
		test_cnt++;
	endtask

	initial begin
		int errs;
		int target;
		int seed;
		int prev_cycle;
		seed = 67;
		void'($urandom(seed));
		rst = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		flush = 1'b0;
		inst_ready = 1'b1;
		$readmemh(ROM_IMAGE, ref_rom);
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;

		// straight line from reset past the ROM wrap
		errs = err_cnt;
		wait_deliveries(40);
		finish_test("sequential fetch", errs);

		// loop over bytes 0 to 28 whose first pass fills lines 0 to 3
		errs = err_cnt;
		send_redirect(32'd0);
		wait_for_pc(32'd28);
		send_redirect(32'd0);
		timing_on = 1'b1;
		repeat (2) begin
			wait_for_pc(32'd28);
			send_redirect(32'd0);
		end
		timing_on = 1'b0;
		finish_test("hit timing", errs);

		// pc 8 and 72 share line 1
		errs = err_cnt;
		repeat (4) begin
			send_redirect(32'd8);
			wait_for_pc(32'd8);
			send_redirect(32'd72);
			wait_for_pc(32'd72);
		end
		finish_test("conflict", errs);

		// redirect while the block of pc 200 is on its way
		errs = err_cnt;
		send_redirect(32'd200);
		wait_refill(32'd200);
		send_redirect(32'd40);
		wait_deliveries(1);
		check_cnt++;
		if (last_pc !== 32'd40) begin
			report_mismatch("inst_pc", 32'd40, last_pc);
		end
		wait_deliveries(4);
		finish_test("redirect during miss", errs);

		// flush alone with the block of pc 16 just cached
		errs = err_cnt;
		send_redirect(32'd16);
		wait_for_pc(32'd16);
		prev_cycle = last_cycle;
		pulse_flush();
		wait_for_pc(32'd20);
		check_refill_gap(prev_cycle, 32'd20);
		// flush held back until the refill of pc 272 ends
		send_redirect(32'd272);
		wait_refill(32'd272);
		pulse_flush();
		wait_for_pc(32'd272);
		prev_cycle = last_cycle;
		wait_for_pc(32'd276);
		check_refill_gap(prev_cycle, 32'd276);
		wait_deliveries(4);
		finish_test("flush", errs);

		// random stalls with ready high two times in three
		errs = err_cnt;
		send_redirect(32'd16);
		target = n_deliv + 30;
		while (n_deliv < target) begin
			inst_ready = ($urandom % 3) != 0;
			next_cycle();
		end
		inst_ready = 1'b1;
		finish_test("back-pressure", errs);

		repeat (5) next_cycle();
		$display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
logic/fetch_pkg.sv
logic/icache_store.sv
logic/icache_ctrl.sv
logic/fetch_unit.sv
logic/boot_rom.sv
logic/fetch_top.sv
sim/tb_fetch_top.sv
